// ==== sources.f ====
+incdir+verilog
verilog/axi_pkg.sv
verilog/coreinfo_pkg.sv
verilog/beat_fifo.sv
verilog/axi_cmd_master.sv
verilog/coreinfo_slave.sv
verilog/core_ctrl_top.sv
test/tb_core_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The run counts as passed only if the simulation prints the pass line.
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_core_ctrl -f sources.f -o tb_core_ctrl &&
./obj_dir/tb_core_ctrl | tee /dev/stderr | grep -q "^Test passed$" &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }

// ==== test/core_ctrl_trace.txt ====
# columns: op id addr len wdata exp_data exp_rst, all values in hex.
# op R reads len+1 beats of exp_data, op W writes once; exp_rst is core1_rst_n after done.
R 0 00000000 0 00000000 00000002 0
R 3 00000000 3 00000000 00000002 0
R 9 00abc000 7 00000000 00000002 0
# core ID selected by the AXI read ID
R 2 00000004 0 00000000 00000010 0
R 5 00000004 1 00000000 00000011 0
R 7 00000004 0 00000000 ffffffff 0
R 0 00003004 2 00000000 ffffffff 0
R 5 00000008 0 00000000 00000000 0
R 2 0000000c 3 00000000 00000000 0
# core 1 reset control
W 1 0000000c 0 00000010 00000000 0
W 1 0000000c 0 00000011 00000000 1
W 1 00000008 0 00000012 00000000 1
W 1 00000004 0 00000011 00000000 1
W 1 00000008 0 00000011 00000000 0
W 3 00000000 0 00000011 00000000 0
W 6 0001000c 0 00000011 00000000 1
R 5 0000000c 0 00000000 00000000 1
# long bursts under random rd_ready
R 0 00000000 f 00000000 00000002 1
R 5 00000004 f 00000000 00000011 1
R 2 00000004 f 00000000 00000010 1
R f 00000004 f 00000000 ffffffff 1
W 2 00000008 0 00000011 00000000 0
R 5 00000000 f 00000000 00000002 0

// ==== test/tb_core_ctrl.sv ====
// testbench for core_ctrl_top, driven by test/core_ctrl_trace.txt.
// expected values in the trace assume the default settings header.
// run from the project root so that the trace path resolves.

`include "coreinfo_settings.svh"

module tb_core_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IDW        = `CI_AXI_ID_WIDTH;
	localparam int DONE_LIMIT = 400;

	logic           clk_i;
	logic           rst_n;
	logic           cmd_start;
	logic           cmd_write;
	logic [IDW-1:0] cmd_id;
	logic [31:0]    cmd_addr;
	logic [3:0]     cmd_len;
	logic [31:0]    cmd_wdata;
	logic           busy;
	logic           done;
	logic           rd_valid;
	logic           rd_ready = 1'b0;
	logic [31:0]    rd_data;
	logic [IDW-1:0] rd_id;
	logic           rd_last;
	logic           core1_rst_n;

	integer seed     = 32'h485b_40a8;
	int     errors   = 0;
	int     timeouts = 0;
	int     done_cnt = 0;

	// every beat the host accepted, in arrival order.
	logic [31:0]    rx_data[$];
	logic [IDW-1:0] rx_id[$];
	logic           rx_last[$];

	core_ctrl_top u_core_ctrl_top (
		.clk_i       (clk_i),
		.rst_n       (rst_n),
		.cmd_start   (cmd_start),
		.cmd_write   (cmd_write),
		.cmd_id      (cmd_id),
		.cmd_addr    (cmd_addr),
		.cmd_len     (cmd_len),
		.cmd_wdata   (cmd_wdata),
		.busy        (busy),
		.done        (done),
		.rd_valid    (rd_valid),
		.rd_ready    (rd_ready),
		.rd_data     (rd_data),
		.rd_id       (rd_id),
		.rd_last     (rd_last),
		.core1_rst_n (core1_rst_n)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// host side: beat capture, done count and a random rd_ready.
	always @(posedge clk_i) begin
		logic [31:0] rnd;
		rnd = $random(seed);
		if (rd_valid && rd_ready) begin
			rx_data.push_back(rd_data);
			rx_id.push_back(rd_id);
			rx_last.push_back(rd_last);
		end
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
		rd_ready <= rst_n && (rnd[1:0] != 2'b00);
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// one command, then a second start while busy that must be dropped.
	task automatic issue_command(input logic wr, input logic [IDW-1:0] id,
		input logic [31:0] addr, input logic [3:0] len, input logic [31:0] wdata);
		@(posedge clk_i);
		cmd_start <= 1'b1;
		cmd_write <= wr;
		cmd_id    <= id;
		cmd_addr  <= addr;
		cmd_len   <= len;
		cmd_wdata <= wdata;
		@(posedge clk_i);
		cmd_write <= 1'b1;
		cmd_id    <= '0;
		cmd_addr  <= 32'h0000_0008;
		cmd_len   <= '0;
		cmd_wdata <= `CI_CORE1_ID;
		@(posedge clk_i);
		check_value("busy after start", 32'd1, 32'(busy));
		cmd_start <= 1'b0;
	endtask

	task automatic wait_done(input int limit, output logic got);
		int cycles;
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < limit) begin
			@(posedge clk_i);
			got = done;
			cycles++;
		end
	endtask

	initial begin
		int               fd;
		int               code;
		int               issued;
		int               base;
		int               n_beats;
		int               exp_beats;
		logic             running;
		logic             got;
		logic [7:0]       op;
		logic [8*128-1:0] skip_line;
		logic [IDW-1:0]   t_id;
		logic [31:0]      t_addr;
		logic [3:0]       t_len;
		logic [31:0]      t_wdata;
		logic [31:0]      exp_data;
		logic             exp_rst;

		rst_n     = 1'b0;
		cmd_start = 1'b0;
		cmd_write = 1'b0;
		cmd_id    = '0;
		cmd_addr  = '0;
		cmd_len   = '0;
		cmd_wdata = '0;
		issued    = 0;
		repeat (16) @(posedge clk_i);
		rst_n <= 1'b1;
		@(posedge clk_i);
		check_value("reset core1_rst_n", 32'd0, 32'(core1_rst_n));
		check_value("reset busy", 32'd0, 32'(busy));
		check_value("reset rd_valid", 32'd0, 32'(rd_valid));

		fd = $fopen("test/core_ctrl_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file test/core_ctrl_trace.txt.");
			errors++;
		end else begin
			running = 1'b1;
			while (running && $fscanf(fd, " %c", op) == 1) begin
				if (op == "#") begin
					code = $fgets(skip_line, fd);
				end else begin
					code = $fscanf(fd, " %h %h %h %h %h %h", t_id, t_addr, t_len, t_wdata,
						exp_data, exp_rst);
					if (code != 6 || (op != "R" && op != "W")) begin
						$display("Trace entry after command %0d is malformed.", issued);
						errors++;
						running = 1'b0;
					end else begin
						base = rx_data.size();
						issue_command(op == "W", t_id, t_addr, t_len, t_wdata);
						issued++;
						wait_done(DONE_LIMIT, got);
						if (!got) begin
							$display("Command %0d never signalled done.", issued);
							errors++;
							timeouts++;
							running = 1'b0;
						end else begin
							n_beats   = rx_data.size() - base;
							exp_beats = (op == "W") ? 0 : int'(t_len) + 1;
							check_value($sformatf("cmd %0d beat count", issued),
								32'(exp_beats), 32'(n_beats));
							for (int i = 0; i < n_beats && i < exp_beats; i++) begin
								check_value($sformatf("cmd %0d beat %0d data", issued, i),
									exp_data, rx_data[base+i]);
								check_value($sformatf("cmd %0d beat %0d id", issued, i),
									32'(t_id), 32'(rx_id[base+i]));
								check_value($sformatf("cmd %0d beat %0d last", issued, i),
									32'(i == int'(t_len)), 32'(rx_last[base+i]));
							end
							check_value($sformatf("cmd %0d core1_rst_n", issued),
								32'(exp_rst), 32'(core1_rst_n));
						end
					end
				end
			end
			$fclose(fd);
		end

		// the monitor needs a few edges to count the last done pulse.
		repeat (4) @(posedge clk_i);
		check_value("done pulses", 32'(issued), 32'(done_cnt));

		$display("Errors: %0d, of which timeouts: %0d", errors, timeouts);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/core_ctrl_top.sv ====
// two-core cluster control block: command master, read-beat FIFO and
// core-info slave. host commands are single-beat writes or 1 to 16 beat
// reads; a start while busy is dropped.

`include "coreinfo_settings.svh"

module core_ctrl_top import axi_pkg::*, coreinfo_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n,
	input  logic        cmd_start,
	input  logic        cmd_write,
	input  axi_id_t     cmd_id,
	input  logic [31:0] cmd_addr,
	input  axi_len_t    cmd_len,
	input  logic [31:0] cmd_wdata,
	output logic        busy,
	output logic        done,
	output logic        rd_valid,
	input  logic        rd_ready,
	output logic [31:0] rd_data,
	output axi_id_t     rd_id,
	output logic        rd_last,
	output logic        core1_rst_n
);

	// one R beat in the FIFO is data, ID and last flag.
	localparam int BEAT_W = 32 + `CI_AXI_ID_WIDTH + 1;

	logic        arvalid;
	logic        arready;
	axi_id_t     arid;
	ci_addr_u    araddr;
	axi_len_t    arlen;
	logic        awvalid;
	logic        awready;
	axi_id_t     awid;
	ci_addr_u    awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        wlast;
	logic        bvalid;
	logic        bready;
	axi_id_t     bid;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	axi_id_t     rid;
	logic        rlast;
	logic        fifo_valid;
	logic        fifo_ready;
	logic [31:0] fifo_data;
	axi_id_t     fifo_id;
	logic        fifo_last;

	axi_cmd_master u_master (
		.clk_i      (clk_i),
		.rst_n      (rst_n),
		.cmd_start  (cmd_start),
		.cmd_write  (cmd_write),
		.cmd_id     (cmd_id),
		.cmd_addr   (cmd_addr),
		.cmd_len    (cmd_len),
		.cmd_wdata  (cmd_wdata),
		.busy       (busy),
		.done       (done),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.rd_data    (rd_data),
		.rd_id      (rd_id),
		.rd_last    (rd_last),
		.arvalid    (arvalid),
		.arid       (arid),
		.araddr     (araddr),
		.arlen      (arlen),
		.awvalid    (awvalid),
		.awid       (awid),
		.awaddr     (awaddr),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wlast      (wlast),
		.bready     (bready),
		.arready    (arready),
		.awready    (awready),
		.wready     (wready),
		.bvalid     (bvalid),
		.bid        (bid),
		.fifo_valid (fifo_valid),
		.fifo_ready (fifo_ready),
		.fifo_data  (fifo_data),
		.fifo_id    (fifo_id),
		.fifo_last  (fifo_last)
	);

	beat_fifo #(
		.WIDTH (BEAT_W),
		.DEPTH (`CI_FIFO_DEPTH)
	) u_fifo (
		.clk_i      (clk_i),
		.rst_n      (rst_n),
		.push_valid (rvalid),
		.push_ready (rready),
		.push_data  ({rdata, rid, rlast}),
		.pop_valid  (fifo_valid),
		.pop_ready  (fifo_ready),
		.pop_data   ({fifo_data, fifo_id, fifo_last})
	);

	coreinfo_slave u_slave (
		.clk_i       (clk_i),
		.rst_n       (rst_n),
		.arvalid     (arvalid),
		.arid        (arid),
		.araddr      (araddr),
		.arlen       (arlen),
		.arready     (arready),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rid         (rid),
		.rlast       (rlast),
		.rresp       (),
		.awvalid     (awvalid),
		.awid        (awid),
		.awaddr      (awaddr),
		.awready     (awready),
		.wvalid      (wvalid),
		.wdata       (wdata),
		.wlast       (wlast),
		.wready      (wready),
		.bvalid      (bvalid),
		.bready      (bready),
		.bid         (bid),
		.bresp       (),
		.core1_rst_n (core1_rst_n)
	);

endmodule

// ==== verilog/coreinfo_slave.sv ====
// AXI4 slave with the core-count and core-ID registers and core 1 reset.
// every beat of a read burst returns the same register; responses are OKAY.
// core 1 comes out of reset in held state until CLR_RST is written.

`include "coreinfo_settings.svh"

module coreinfo_slave import axi_pkg::*, coreinfo_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n,

	input  logic        arvalid,
	input  axi_id_t     arid,
	input  ci_addr_u    araddr,
	input  axi_len_t    arlen,
	output logic        arready,

	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output axi_id_t     rid,
	output logic        rlast,
	output axi_resp_e   rresp,

	input  logic        awvalid,
	input  axi_id_t     awid,
	input  ci_addr_u    awaddr,
	output logic        awready,

	input  logic        wvalid,
	input  logic [31:0] wdata,
	input  logic        wlast,
	output logic        wready,

	output logic        bvalid,
	input  logic        bready,
	output axi_id_t     bid,
	output axi_resp_e   bresp,

	output logic        core1_rst_n
);

	localparam logic [1:0] RD_IDLE = 2'd0;
	localparam logic [1:0] RD_GAP  = 2'd1;
	localparam logic [1:0] RD_DATA = 2'd2;

	localparam logic [1:0] WR_IDLE = 2'd0;
	localparam logic [1:0] WR_DATA = 2'd1;
	localparam logic [1:0] WR_RESP = 2'd2;

	logic [1:0]  rd_state;
	ci_reg_e     rd_reg;
	axi_id_t     rd_id_q;
	axi_len_t    rd_len;
	axi_len_t    rd_cnt;
	logic [31:0] core_id;

	logic [1:0]  wr_state;
	ci_reg_e     wr_reg;
	axi_id_t     wr_id_q;

	// read side.
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (arvalid && arready) begin
						rd_state <= RD_GAP;
					end
				end
				// one dead cycle before the first beat.
				RD_GAP: begin
					rd_state <= RD_DATA;
				end
				RD_DATA: begin
					if (rvalid && rready && rlast) begin
						rd_state <= RD_IDLE;
					end
				end
				default: begin
					rd_state <= RD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (arvalid && arready) begin
			rd_reg  <= araddr.f.reg_sel;
			rd_id_q <= arid;
			rd_len  <= arlen;
			rd_cnt  <= '0;
		end else if (rvalid && rready) begin
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// the requesting core is known only by its AXI read ID.
	always_comb begin
		if (rd_id_q == axi_id_t'(`CI_CORE0_AXI_ID)) begin
			core_id = `CI_CORE0_ID;
		end else if (rd_id_q == axi_id_t'(`CI_CORE1_AXI_ID)) begin
			core_id = `CI_CORE1_ID;
		end else begin
			core_id = '1;
		end
	end

	always_comb begin
		case (rd_reg)
			N_CORES: rdata = CI_N_CORES;
			CORE_ID: rdata = core_id;
			default: rdata = '0;
		endcase
	end

	assign arready = (rd_state == RD_IDLE);
	assign rvalid  = (rd_state == RD_DATA);
	assign rlast   = rvalid && (rd_cnt == rd_len);
	assign rid     = rd_id_q;
	assign rresp   = OKAY;

	// write side.
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			wr_state    <= WR_IDLE;
			core1_rst_n <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (awvalid && awready) begin
						wr_state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (wvalid && wready) begin
						if (wlast) begin
							wr_state <= WR_RESP;
						end
						// only the ID of core 1 acts on its reset.
						if (wdata == `CI_CORE1_ID) begin
							if (wr_reg == SET_RST) begin
								core1_rst_n <= 1'b0;
							end else if (wr_reg == CLR_RST) begin
								core1_rst_n <= 1'b1;
							end
						end
					end
				end
				WR_RESP: begin
					if (bvalid && bready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: begin
					wr_state <= WR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (awvalid && awready) begin
			wr_reg  <= awaddr.f.reg_sel;
			wr_id_q <= awid;
		end
	end

	assign awready = (wr_state == WR_IDLE);
	assign wready  = (wr_state == WR_DATA);
	assign bvalid  = (wr_state == WR_RESP);
	assign bid     = wr_id_q;
	assign bresp   = OKAY;

	// the beat counter never runs past the end of the burst.
	a_cnt_in_burst: assert property (@(posedge clk_i) disable iff (!rst_n)
		rvalid |-> rd_cnt <= rd_len);

	a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n)
		!$isunknown({rvalid, bvalid}));

endmodule

// ==== verilog/axi_cmd_master.sv ====
// turns host commands into AXI4 transactions on the core-info slave.
// writes are always single beat with WLAST set; reads may be 1 to 16 beats.
// a start pulse while busy is ignored. read beats are handed to the host
// straight from the beat FIFO.

module axi_cmd_master import axi_pkg::*, coreinfo_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_n,

	input  logic        cmd_start,
	input  logic        cmd_write,
	input  axi_id_t     cmd_id,
	input  logic [31:0] cmd_addr,
	input  axi_len_t    cmd_len,
	input  logic [31:0] cmd_wdata,
	output logic        busy,
	output logic        done,

	output logic        rd_valid,
	input  logic        rd_ready,
	output logic [31:0] rd_data,
	output axi_id_t     rd_id,
	output logic        rd_last,

	output logic        arvalid,
	output axi_id_t     arid,
	output ci_addr_u    araddr,
	output axi_len_t    arlen,
	output logic        awvalid,
	output axi_id_t     awid,
	output ci_addr_u    awaddr,
	output logic        wvalid,
	output logic [31:0] wdata,
	output logic        wlast,
	output logic        bready,

	input  logic        arready,
	input  logic        awready,
	input  logic        wready,
	input  logic        bvalid,
	input  axi_id_t     bid,

	input  logic        fifo_valid,
	output logic        fifo_ready,
	input  logic [31:0] fifo_data,
	input  axi_id_t     fifo_id,
	input  logic        fifo_last
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ADDR   = 2'd1;
	localparam logic [1:0] ST_RESP   = 2'd2;
	localparam logic [1:0] ST_FINISH = 2'd3;

	logic [1:0]  state;
	logic        wr_q;
	axi_id_t     id_q;
	logic [31:0] addr_q;
	axi_len_t    len_q;
	logic [31:0] wdata_q;

	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic host_hs;

	assign ar_hs   = arvalid && arready;
	assign aw_hs   = awvalid && awready;
	assign w_hs    = wvalid && wready;
	assign b_hs    = bvalid && bready;
	assign host_hs = rd_valid && rd_ready;

	assign busy = (state != ST_IDLE);

	// command fields, captured when a command is accepted.
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && cmd_start) begin
			wr_q    <= cmd_write;
			id_q    <= cmd_id;
			addr_q  <= cmd_addr;
			len_q   <= cmd_len;
			wdata_q <= cmd_wdata;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			done    <= 1'b0;
			arvalid <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd_start) begin
						state   <= ST_ADDR;
						arvalid <= !cmd_write;
						awvalid <= cmd_write;
						wvalid  <= cmd_write;
					end
				end
				ST_ADDR: begin
					// each channel drops its valid on its own transfer.
					if (ar_hs) begin
						arvalid <= 1'b0;
					end
					if (aw_hs) begin
						awvalid <= 1'b0;
					end
					if (w_hs) begin
						wvalid <= 1'b0;
					end
					if ((!arvalid || ar_hs) && (!awvalid || aw_hs) && (!wvalid || w_hs)) begin
						state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (wr_q ? b_hs : (host_hs && rd_last)) begin
						state <= ST_FINISH;
					end
				end
				ST_FINISH: begin
					done  <= 1'b1;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign arid       = id_q;
	assign araddr.raw = addr_q;
	assign arlen      = len_q;
	assign awid       = id_q;
	assign awaddr.raw = addr_q;
	assign wdata      = wdata_q;
	assign wlast      = 1'b1;
	assign bready     = (state == ST_RESP) && wr_q;

	// read beats go to the host unchanged.
	assign rd_valid   = fifo_valid;
	assign fifo_ready = rd_ready;
	assign rd_data    = fifo_data;
	assign rd_id      = fifo_id;
	assign rd_last    = fifo_last;

	a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

	// the slave must answer a write with the ID it was given.
	a_bid_match: assert property (@(posedge clk_i) disable iff (!rst_n)
		b_hs |-> bid == id_q);

endmodule

// ==== verilog/beat_fifo.sv ====
// valid/ready FIFO for read-data beats.
// DEPTH must be a power of two so the pointers wrap on their own.
// push_ready is low only when full; data is readable the cycle after a push.

module beat_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk_i,
	input  logic             rst_n,
	input  logic             push_valid,
	output logic             push_ready,
	input  logic [WIDTH-1:0] push_data,
	output logic             pop_valid,
	input  logic             pop_ready,
	output logic [WIDTH-1:0] pop_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid  = (count != '0);
	assign pop_data   = mem[rd_ptr];

	assign do_push = push_valid && push_ready;
	assign do_pop  = pop_valid && pop_ready;

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leave the count alone.
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// a full FIFO never grows past its depth.
	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n)
		count == CNT_W'(DEPTH) |=> count <= CNT_W'(DEPTH));

	// an empty FIFO either stays empty or takes one beat.
	a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n)
		count == '0 |=> count <= CNT_W'(1));

endmodule

// ==== verilog/coreinfo_pkg.sv ====
// register map and address layout of the core-info block.
// registers are 32-bit words; only the low two bits of the word index
// select a register, so the map repeats through each page.

package coreinfo_pkg;

	// number of cores reported by the N_CORES register.
	localparam logic [31:0] CI_N_CORES = 32'd2;

	// register index, taken from the word address.
	typedef enum logic [1:0] {
		N_CORES = 2'd0,
		CORE_ID = 2'd1,
		SET_RST = 2'd2,
		CLR_RST = 2'd3
	} ci_reg_e;

	// one address word, seen either as a raw bus value or as fields.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [19:0] page;
			// upper bits of the word index, ignored by the slave.
			logic [7:0]  word_hi;
			ci_reg_e     reg_sel;
			logic [1:0]  byte_off;
		} f;
	} ci_addr_u;

endpackage

// ==== verilog/axi_pkg.sv ====
// AXI4 field types shared by the master, the slave and the top level.
// only OKAY responses are produced in this design.

`include "coreinfo_settings.svh"

package axi_pkg;

	// transaction ID, sized by the settings header.
	typedef logic [`CI_AXI_ID_WIDTH-1:0] axi_id_t;

	// burst length minus one, so 0 to 15 means 1 to 16 beats.
	typedef logic [3:0] axi_len_t;

	// response codes.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

endpackage

// ==== verilog/coreinfo_settings.svh ====
// build-time settings of the core-info cluster block.
// the FIFO depth must be a power of two.
// core IDs are 32 bits wide; AXI IDs must fit in CI_AXI_ID_WIDTH bits.

`ifndef COREINFO_SETTINGS_SVH
`define COREINFO_SETTINGS_SVH

// width of every AXI ID field.
`define CI_AXI_ID_WIDTH 4

// AXI read IDs by which the slave tells the two cores apart.
`define CI_CORE0_AXI_ID 2
`define CI_CORE1_AXI_ID 5

// core IDs reported through the CORE_ID register.
`define CI_CORE0_ID 32'h10
`define CI_CORE1_ID 32'h11

// number of read beats held between slave and master.
`define CI_FIFO_DEPTH 4

`endif
